// File: logic/core_pkg.sv
// Shared widths, instruction field codes and state encodings
// for the RV32I integer pipeline

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  localparam int REG_ADDR_WIDTH = 5;    // Register index width
  localparam int NUM_REGS       = 32;   // x0..x31

  typedef logic [31:0]               word_t;      // Data or address word
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;  // Register index
  typedef logic [6:0]                opcode_t;    // Major opcode incl. bits [1:0]

  localparam word_t PC_STEP = 32'd4;  // No compressed instructions

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings

  localparam opcode_t OPCODE_OP    = 7'h33;  // Register-register
  localparam opcode_t OPCODE_OPIMM = 7'h13;  // Register-immediate
  localparam opcode_t OPCODE_LUI   = 7'h37;

  localparam logic [2:0] FUNCT3_ADD = 3'b000;  // Also SUB with FUNCT7_SUB
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  ////////////////////////////////////////////////////////////////////////////
  // State and operation encodings

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B      // For LUI operand b carries the U immediate
  } alu_op_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

endpackage

// File: logic/id_ex_if.sv
// Decode to execute bundle
// One decoded operation per valid strobe and no back-pressure

interface id_ex_if;

  import core_pkg::*;

  logic      valid;      // One-cycle strobe
  alu_op_e   op;
  word_t     operand_a;
  word_t     operand_b;
  reg_addr_t rd;
  logic      we;         // Result goes to rd
  word_t     pc;

  // Driven by the decoder
  modport master (
    output valid, op, operand_a, operand_b, rd, we, pc
  );

  // Consumed by the ALU stage
  modport slave (
    input  valid, op, operand_a, operand_b, rd, we, pc
  );

endinterface

// File: logic/riscv_fetch.sv
// Instruction fetch over the req/gnt/rvalid memory port
// One outstanding request and a one-entry buffer towards decode

module riscv_fetch (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,
  // Instruction memory
  output logic           instr_req_o,
  output core_pkg::word_t instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  core_pkg::word_t instr_rdata_i,
  // To decode
  output logic           instr_valid_o,
  output core_pkg::word_t instr_o,
  output core_pkg::word_t pc_o,
  input  logic           take_i           // Decode consumes the buffer
);

  import core_pkg::*;

  fetch_state_e state_q;
  word_t        fetch_pc_q;   // Address of next/current request
  logic         buf_valid_q;
  word_t        buf_instr_q;
  word_t        buf_pc_q;

  // Buffer free now or freed this cycle
  logic buf_free;
  assign buf_free = ~buf_valid_q | take_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= FETCH_IDLE;
      fetch_pc_q <= boot_addr_i;
    end else begin
      unique case (state_q)
        FETCH_IDLE: begin
          if (fetch_enable_i && buf_free) state_q <= FETCH_WAIT_GNT;
        end
        FETCH_WAIT_GNT: begin
          if (instr_gnt_i) state_q <= FETCH_WAIT_RVALID;  // Addr accepted
        end
        FETCH_WAIT_RVALID: begin
          if (instr_rvalid_i) begin
            state_q    <= FETCH_IDLE;
            fetch_pc_q <= fetch_pc_q + PC_STEP;  // Sequential only
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  // Fill and take never coincide
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
    end else if (state_q == FETCH_WAIT_RVALID && instr_rvalid_i) begin
      buf_valid_q <= 1'b1;
    end else if (take_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  // Buffer payload
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH_WAIT_RVALID && instr_rvalid_i) begin
      buf_instr_q <= instr_rdata_i;
      buf_pc_q    <= fetch_pc_q;
    end
  end

  assign instr_req_o   = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o  = fetch_pc_q;
  assign instr_valid_o = buf_valid_q;
  assign instr_o       = buf_instr_q;
  assign pc_o          = buf_pc_q;

  // Request and address held until granted
  a_req_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

// File: logic/riscv_regfile.sv
// Integer register file with 2 read ports and 1 write port
// x0 reads as zero and same-cycle reads see the write

module riscv_regfile (
  input  logic               clk_i,
  input  logic               reset_i,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  input  logic               we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o
);

  import core_pkg::*;

  word_t regs_q [NUM_REGS];

  logic wr_en;
  assign wr_en = we_i && (waddr_i != '0);  // x0 never written

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Bypass the write of this cycle into both read ports
  assign rdata_a_o = (wr_en && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (wr_en && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];

endmodule

// File: logic/riscv_decoder.sv
// Decode stage with field split, immediates, ALU op select,
// RAW hazard stall, illegal instruction flag and ID/EX register

module riscv_decoder (
  input  logic               clk_i,
  input  logic               reset_i,
  // From fetch
  input  logic               instr_valid_i,
  input  core_pkg::word_t     instr_i,
  input  core_pkg::word_t     pc_i,
  output logic               take_o,
  // Register file read
  output core_pkg::reg_addr_t raddr_a_o,
  output core_pkg::reg_addr_t raddr_b_o,
  input  core_pkg::word_t     rdata_a_i,
  input  core_pkg::word_t     rdata_b_i,
  // Destination about to be committed
  input  core_pkg::reg_addr_t wb_rd_i,
  input  logic               wb_we_i,
  output logic               illegal_insn_o,
  id_ex_if.master            id_ex_o
);

  import core_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1, rs2, rd;
  word_t      imm_i, imm_u;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};  // Sign-extended
  assign imm_u = {instr_i[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Operation decode

  alu_op_e f3_op;   // Op from funct3 shared by OP and OP-IMM
  logic    f3_ok;

  always_comb begin
    f3_ok = 1'b1;
    unique case (funct3)
      FUNCT3_ADD: f3_op = ALU_ADD;
      FUNCT3_XOR: f3_op = ALU_XOR;
      FUNCT3_OR:  f3_op = ALU_OR;
      FUNCT3_AND: f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;  // SLT, shifts etc. not supported
      end
    endcase
  end

  alu_op_e dec_op;
  word_t   dec_b;
  logic    dec_illegal, dec_we, use_rs1, use_rs2;

  always_comb begin
    dec_op      = f3_op;
    dec_b       = rdata_b_i;
    dec_illegal = 1'b0;
    dec_we      = 1'b1;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    unique case (opcode)
      OPCODE_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        if (funct7 == FUNCT7_SUB && funct3 == FUNCT3_ADD) begin
          dec_op = ALU_SUB;
        end else if (funct7 != '0 || !f3_ok) begin
          dec_illegal = 1'b1;
        end
      end
      OPCODE_OPIMM: begin
        use_rs1     = 1'b1;
        dec_b       = imm_i;
        dec_illegal = ~f3_ok;
      end
      OPCODE_LUI: begin
        dec_op = ALU_PASS_B;
        dec_b  = imm_u;
      end
      default: begin
        dec_illegal = 1'b1;  // Loads, stores, branches, system, ...
        dec_we      = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hazard stall without forwarding paths

  logic ex_busy, a_stall, b_stall;
  assign ex_busy = id_ex_o.valid && id_ex_o.we;  // Result one stage ahead
  assign a_stall = use_rs1 && rs1 != '0 &&
                   ((ex_busy && rs1 == id_ex_o.rd) || (wb_we_i && rs1 == wb_rd_i));
  assign b_stall = use_rs2 && rs2 != '0 &&
                   ((ex_busy && rs2 == id_ex_o.rd) || (wb_we_i && rs2 == wb_rd_i));

  assign take_o         = instr_valid_i & ~(a_stall | b_stall);
  assign illegal_insn_o = take_o & dec_illegal;  // Dropped and never retires
  assign raddr_a_o      = rs1;
  assign raddr_b_o      = rs2;

  // ID/EX register
  always_ff @(posedge clk_i) begin
    if (reset_i) id_ex_o.valid <= 1'b0;
    else         id_ex_o.valid <= take_o & ~dec_illegal;
  end

  always_ff @(posedge clk_i) begin
    if (take_o) begin
      id_ex_o.op        <= dec_op;
      id_ex_o.operand_a <= rdata_a_i;  // Don't care for LUI
      id_ex_o.operand_b <= dec_b;
      id_ex_o.rd        <= rd;
      id_ex_o.we        <= dec_we;
      id_ex_o.pc        <= pc_i;
    end
  end

  // A stalled instruction stays put until decode takes it
  a_hold_until_take : assert property (@(posedge clk_i) disable iff (reset_i)
    instr_valid_i && !take_o |=> instr_valid_i && $stable(instr_i) && $stable(pc_i));

endmodule

// File: logic/riscv_alu.sv
// Execute stage with the ALU on the decoded operands
// and the result registered with rd, we and pc for writeback

module riscv_alu (
  input  logic               clk_i,
  input  logic               reset_i,
  id_ex_if.slave             id_ex_i,
  output logic               ex_valid_o,
  output core_pkg::reg_addr_t ex_rd_o,
  output logic               ex_we_o,
  output core_pkg::word_t     ex_result_o,
  output core_pkg::word_t     ex_pc_o
);

  import core_pkg::*;

  word_t result;

  always_comb begin
    unique case (id_ex_i.op)
      ALU_ADD:    result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:    result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND:    result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:     result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR:    result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_PASS_B: result = id_ex_i.operand_b;  // LUI
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) ex_valid_o <= 1'b0;
    else         ex_valid_o <= id_ex_i.valid;  // Every strobe accepted
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (id_ex_i.valid) begin
      ex_result_o <= result;
      ex_rd_o     <= id_ex_i.rd;
      ex_we_o     <= id_ex_i.we;
      ex_pc_o     <= id_ex_i.pc;
    end
  end

  // Decoder must never issue an undefined op
  a_op_known : assert property (@(posedge clk_i) disable iff (reset_i)
    id_ex_i.valid |-> !$isunknown(id_ex_i.op));

endmodule

// File: logic/riscv_writeback.sv
// Writeback stage with commit to the register file,
// retire report and destination feedback to decode

module riscv_writeback (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               ex_valid_i,
  input  core_pkg::reg_addr_t ex_rd_i,
  input  logic               ex_we_i,
  input  core_pkg::word_t     ex_result_i,
  input  core_pkg::word_t     ex_pc_i,
  // Register file write port
  output logic               rf_we_o,
  output core_pkg::reg_addr_t rf_waddr_o,
  output core_pkg::word_t     rf_wdata_o,
  // Hazard feedback
  output core_pkg::reg_addr_t wb_rd_o,
  output logic               wb_we_o,
  // Retire report
  output logic               retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::reg_addr_t retire_rd_o,
  output core_pkg::word_t     retire_data_o
);

  import core_pkg::*;

  logic      valid_q, we_q;
  reg_addr_t rd_q;
  word_t     data_q, pc_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) valid_q <= 1'b0;
    else         valid_q <= ex_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      rd_q   <= ex_rd_i;
      we_q   <= ex_we_i;
      data_q <= ex_result_i;
      pc_q   <= ex_pc_i;
    end
  end

  // Commit with x0 filtered in the register file
  assign rf_we_o    = valid_q & we_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = data_q;

  // Result entering this stage as the one in it is bypassed by the regfile
  assign wb_rd_o = ex_rd_i;
  assign wb_we_o = ex_valid_i & ex_we_i;

  assign retire_valid_o = valid_q;
  assign retire_pc_o    = pc_q;
  assign retire_rd_o    = rd_q;
  assign retire_data_o  = data_q;  // Reported even for x0

endmodule

// File: logic/riscv_core.sv
// Core top level wiring fetch, decode, execute, writeback
// and the register file together

module riscv_core (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               fetch_enable_i,
  input  core_pkg::word_t     boot_addr_i,
  // Instruction memory
  output logic               instr_req_o,
  output core_pkg::word_t     instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  core_pkg::word_t     instr_rdata_i,
  // Retire report
  output logic               retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::reg_addr_t retire_rd_o,
  output core_pkg::word_t     retire_data_o,
  output logic               illegal_insn_o
);

  import core_pkg::*;

  // IF/ID
  logic      instr_valid, take;
  word_t     instr, pc_id;
  // Register file
  reg_addr_t raddr_a, raddr_b, rf_waddr;
  word_t     rdata_a, rdata_b, rf_wdata;
  logic      rf_we;
  // EX/WB and feedback
  logic      ex_valid, ex_we, wb_we;
  reg_addr_t ex_rd, wb_rd;
  word_t     ex_result, ex_pc;

  id_ex_if id_ex ();

  ////////////////////////////////////////////////////////////////////////////
  // Stages

  riscv_fetch fetch_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_valid_o  ( instr_valid    ),
    .instr_o        ( instr          ),
    .pc_o           ( pc_id          ),
    .take_i         ( take           )
  );

  riscv_regfile regfile_i (
    .clk_i     ( clk_i    ),
    .reset_i   ( reset_i  ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  )
  );

  riscv_decoder decoder_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .instr_valid_i  ( instr_valid    ),
    .instr_i        ( instr          ),
    .pc_i           ( pc_id          ),
    .take_o         ( take           ),
    .raddr_a_o      ( raddr_a        ),
    .raddr_b_o      ( raddr_b        ),
    .rdata_a_i      ( rdata_a        ),
    .rdata_b_i      ( rdata_b        ),
    .wb_rd_i        ( wb_rd          ),
    .wb_we_i        ( wb_we          ),
    .illegal_insn_o ( illegal_insn_o ),
    .id_ex_o        ( id_ex.master   )
  );

  riscv_alu alu_i (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .id_ex_i     ( id_ex.slave ),
    .ex_valid_o  ( ex_valid    ),
    .ex_rd_o     ( ex_rd       ),
    .ex_we_o     ( ex_we       ),
    .ex_result_o ( ex_result   ),
    .ex_pc_o     ( ex_pc       )
  );

  riscv_writeback writeback_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .ex_valid_i     ( ex_valid       ),
    .ex_rd_i        ( ex_rd          ),
    .ex_we_i        ( ex_we          ),
    .ex_result_i    ( ex_result      ),
    .ex_pc_i        ( ex_pc          ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .wb_rd_o        ( wb_rd          ),
    .wb_we_o        ( wb_we          ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_data_o  ( retire_data_o  )
  );

endmodule

// File: bench/tb_imem.sv
// Instruction memory model for the core testbench
// Program array loaded by the test tasks and the req/gnt/rvalid protocol
// Seeded random grant delay 0..3 and data delay 1..3 cycles

module tb_imem (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [31:0] base_i,     // Address of program word 0
  input  int          len_i,      // Program length in words
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  localparam int MEM_WORDS = 64;

  logic [31:0] mem [MEM_WORDS];   // Written by the testbench tasks
  integer      seed;
  int          gnt_left;          // Cycles before the next grant
  int          rv_left;           // Extra cycles before rvalid
  int          rv_draw;
  logic        pending;           // Granted, data not returned yet
  logic [31:0] pend_word;
  logic [31:0] offset;
  logic        in_range;

  assign offset   = addr_i - base_i;
  assign in_range = (offset[1:0] == 2'b00) && ((offset >> 2) < len_i);

  // No grant past the program end so fetch just waits
  assign gnt_o = (req_i === 1'b1) && in_range && (gnt_left == 0);

  initial begin
    seed      = 83;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    pending   = 1'b0;
    pend_word = '0;
    gnt_left  = 0;
    rv_left   = 0;
  end

  // Uniform value in 0..span-1
  function automatic int draw(input int span);
    return $unsigned($random(seed)) % span;
  endfunction

  always @(posedge clk_i) begin
    rvalid_o <= 1'b0;                       // Single-cycle strobe
    if (reset_i) begin
      pending  <= 1'b0;
      gnt_left <= draw(4);
    end else begin
      if (gnt_o) begin
        gnt_left <= draw(4);                // Delay for the next request
        rv_draw = draw(3);
        if (rv_draw == 0) begin
          rvalid_o <= 1'b1;                 // Data in the cycle after grant
          rdata_o  <= mem[offset >> 2];
        end else begin
          pending   <= 1'b1;
          rv_left   <= rv_draw - 1;
          pend_word <= mem[offset >> 2];
        end
      end else if (req_i === 1'b1 && in_range && gnt_left != 0) begin
        gnt_left <= gnt_left - 1;           // Count down while the request is held
      end
      if (pending) begin
        if (rv_left == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= pend_word;
          pending  <= 1'b0;
        end else begin
          rv_left <= rv_left - 1;
        end
      end
    end
  end

endmodule

// File: bench/tb_core.sv
// Core testbench with clock, reset, instruction memory model,
// in-order golden model, directed tests, watchdog and report

module tb_core;

  localparam int CLK_PERIOD  = 20;
  localparam int RESET_CYCLES = 10;
  localparam int REQ_TIMEOUT = 10;   // Cycles from enable to first request
  localparam int DRAIN_CYCLES = 6;   // Quiet time after the last retire

  // Instruction counts per test for the watchdog
  localparam int N_IDLE  = 2;
  localparam int N_IMM   = 8;
  localparam int N_DEP   = 7;
  localparam int N_LUI   = 7;
  localparam int N_ILL   = 3;
  localparam int N_MIX   = 40;
  localparam int N_TESTS = 6;
  localparam int TOTAL_INSNS = N_IDLE + N_IMM + N_DEP + N_LUI + N_ILL + N_MIX;
  // 20 cycles per instruction plus reset and drain time per test
  localparam int WATCHDOG_CYCLES = TOTAL_INSNS * 20 + N_TESTS * 40;

  typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR,       // R type kinds first
    K_ADDI, K_ANDI, K_ORI, K_XORI,
    K_LUI
  } kind_e;

  logic        clk;
  logic        reset_i;
  logic        fetch_enable;
  logic [31:0] boot_addr;
  logic        instr_req, instr_gnt, instr_rvalid;
  logic [31:0] instr_addr, instr_rdata;
  logic        retire_valid, illegal_insn;
  logic [31:0] retire_pc, retire_data;
  logic [4:0]  retire_rd;

  // Golden model state and expected stream
  logic [31:0] gold [32];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_data [$];
  logic [4:0]  exp_rd [$];
  int          exp_illegal;
  int          prog_len;

  // Observed stream
  logic [31:0] got_pc [$];
  logic [31:0] got_data [$];
  logic [4:0]  got_rd [$];
  int          got_illegal;

  int     errors, test_errors, tests_run, tests_failed;
  integer seed;

  ////////////////////////////////////////////////////////////////////////////
  // DUT and memory

  riscv_core UUT (
    .clk_i          ( clk          ),
    .reset_i        ( reset_i      ),
    .fetch_enable_i ( fetch_enable ),
    .boot_addr_i    ( boot_addr    ),
    .instr_req_o    ( instr_req    ),
    .instr_addr_o   ( instr_addr   ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_rdata_i  ( instr_rdata  ),
    .retire_valid_o ( retire_valid ),
    .retire_pc_o    ( retire_pc    ),
    .retire_rd_o    ( retire_rd    ),
    .retire_data_o  ( retire_data  ),
    .illegal_insn_o ( illegal_insn )
  );

  tb_imem imem (
    .clk_i    ( clk          ),
    .reset_i  ( reset_i      ),
    .base_i   ( boot_addr    ),
    .len_i    ( prog_len     ),
    .req_i    ( instr_req    ),
    .addr_i   ( instr_addr   ),
    .gnt_o    ( instr_gnt    ),
    .rvalid_o ( instr_rvalid ),
    .rdata_o  ( instr_rdata  )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Retire and illegal monitor at mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (!reset_i) begin
      if (retire_valid) begin
        got_pc.push_back(retire_pc);
        got_rd.push_back(retire_rd);
        got_data.push_back(retire_data);
      end
      if (illegal_insn) got_illegal++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Encoding and reference semantics from the RV32I spec

  function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [31:0] src);
    // src is rs2 for R type, imm[11:0] for I type, imm[31:12] for LUI
    case (k)
      K_ADD:   return {7'h00, src[4:0], rs1, 3'b000, rd, 7'h33};
      K_SUB:   return {7'h20, src[4:0], rs1, 3'b000, rd, 7'h33};
      K_AND:   return {7'h00, src[4:0], rs1, 3'b111, rd, 7'h33};
      K_OR:    return {7'h00, src[4:0], rs1, 3'b110, rd, 7'h33};
      K_XOR:   return {7'h00, src[4:0], rs1, 3'b100, rd, 7'h33};
      K_ADDI:  return {src[11:0], rs1, 3'b000, rd, 7'h13};
      K_ANDI:  return {src[11:0], rs1, 3'b111, rd, 7'h13};
      K_ORI:   return {src[11:0], rs1, 3'b110, rd, 7'h13};
      K_XORI:  return {src[11:0], rs1, 3'b100, rd, 7'h13};
      default: return {src[19:0], rd, 7'h37};
    endcase
  endfunction

  function automatic logic [31:0] reference(input kind_e k, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] src);
    logic [31:0] imm;
    imm = {{20{src[11]}}, src[11:0]};       // Sign-extended I immediate
    case (k)
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_AND:   return a & b;
      K_OR:    return a | b;
      K_XOR:   return a ^ b;
      K_ADDI:  return a + imm;
      K_ANDI:  return a & imm;
      K_ORI:   return a | imm;
      K_XORI:  return a ^ imm;
      default: return {src[19:0], 12'h000};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test helpers

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      count_error();
    end
  endtask

  // Core held in reset while the program and golden state are rebuilt
  task automatic begin_test(input logic [31:0] boot);
    @(posedge clk);
    reset_i      <= 1'b1;
    fetch_enable <= 1'b0;
    boot_addr    <= boot;
    repeat (RESET_CYCLES) @(posedge clk);
    for (int i = 0; i < 32; i++) gold[i] = '0;
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    got_pc.delete();
    got_rd.delete();
    got_data.delete();
    exp_illegal = 0;
    got_illegal = 0;
    prog_len    = 0;
    test_errors = 0;
  endtask

  // Append one instruction and run it on the golden model
  task automatic emit(input kind_e k, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [31:0] src);
    logic [31:0] result;
    imem.mem[prog_len] = encode(k, rd, rs1, src);
    result = reference(k, gold[rs1], gold[src[4:0]], src);
    exp_pc.push_back(boot_addr + prog_len * 4);
    exp_rd.push_back(rd);
    exp_data.push_back(result);
    if (rd != 5'd0) gold[rd] = result;      // x0 stays zero
    prog_len++;
  endtask

  task automatic emit_illegal(input logic [31:0] word);
    imem.mem[prog_len] = word;
    exp_illegal++;
    prog_len++;
  endtask

  task automatic run_program(input string name, input int idle_cycles);
    int waited;
    int n;
    @(posedge clk);
    reset_i <= 1'b0;
    repeat (idle_cycles) begin
      @(negedge clk);
      assert (!instr_req && !retire_valid && !illegal_insn) else begin
        $display("Core active after reset while fetch is disabled");
        count_error();
      end
    end
    @(posedge clk);
    fetch_enable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!instr_req && waited < REQ_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (instr_req) else begin
      $display("No instruction request within %0d cycles of enable", REQ_TIMEOUT);
      count_error();
    end
    if (instr_req) check_word("instr_addr_o", boot_addr, instr_addr);
    // Wait for every expected retire
    while (got_pc.size() < exp_pc.size()) @(negedge clk);
    repeat (DRAIN_CYCLES) @(negedge clk);
    check_word("retire count", exp_pc.size(), got_pc.size());
    check_word("illegal_insn_o count", exp_illegal, got_illegal);
    n = (got_pc.size() < exp_pc.size()) ? got_pc.size() : exp_pc.size();
    for (int i = 0; i < n; i++) begin
      check_word("retire_pc_o", exp_pc[i], got_pc[i]);
      check_word("retire_rd_o", {27'b0, exp_rd[i]}, {27'b0, got_rd[i]});
      check_word("retire_data_o", exp_data[i], got_data[i]);
    end
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %s finished, %0d retires, %0d errors", name, got_pc.size(), test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic idle_then_boot();
    begin_test(32'h0000_2000);
    emit(K_ADDI, 5'd1, 5'd0, 32'h123);
    emit(K_XORI, 5'd2, 5'd1, 32'hFFF);      // NOT of x1
    run_program("idle_then_boot", 8);
  endtask

  task automatic immediate_ops();
    begin_test(32'h0000_0100);
    emit(K_ADDI, 5'd1, 5'd0, 32'h064);
    emit(K_ADDI, 5'd2, 5'd0, 32'hFF9);      // -7
    emit(K_ORI,  5'd3, 5'd0, 32'h5A5);
    emit(K_XORI, 5'd4, 5'd0, 32'hFFF);
    emit(K_ANDI, 5'd5, 5'd1, 32'h0F0);
    emit(K_ADDI, 5'd6, 5'd0, 32'h800);      // Most negative immediate
    emit(K_ORI,  5'd7, 5'd0, 32'hFF0);
    emit(K_ANDI, 5'd8, 5'd2, 32'hF00);
    run_program("immediate_ops", 0);
  endtask

  // Each op reads the previous rd and stalls on every step
  task automatic dependent_chain();
    begin_test(32'h0000_0100);
    emit(K_ADDI, 5'd1, 5'd0, 32'h035);
    emit(K_ADDI, 5'd2, 5'd1, 32'hFFD);
    emit(K_ADD,  5'd3, 5'd1, 32'd2);
    emit(K_SUB,  5'd4, 5'd3, 32'd2);
    emit(K_AND,  5'd5, 5'd4, 32'd1);
    emit(K_OR,   5'd6, 5'd5, 32'd2);
    emit(K_XOR,  5'd7, 5'd6, 32'd5);
    run_program("dependent_chain", 0);
  endtask

  task automatic lui_and_x0();
    begin_test(32'h0000_0400);
    emit(K_LUI,  5'd1, 5'd0, 32'hABCDE);
    emit(K_LUI,  5'd2, 5'd0, 32'h80000);
    emit(K_ADDI, 5'd0, 5'd1, 32'h055);      // Retires but leaves x0 unchanged
    emit(K_ADD,  5'd3, 5'd0, 32'd1);
    emit(K_LUI,  5'd0, 5'd0, 32'h12345);
    emit(K_OR,   5'd4, 5'd0, 32'd2);
    emit(K_XOR,  5'd5, 5'd0, 32'd0);
    run_program("lui_and_x0", 0);
  endtask

  task automatic illegal_in_stream();
    begin_test(32'h0000_0100);
    emit(K_ADDI, 5'd1, 5'd0, 32'h007);
    emit_illegal(32'h0000_2083);            // LW x1, 0(x0)
    emit(K_ADDI, 5'd2, 5'd1, 32'h001);
    run_program("illegal_in_stream", 0);
  endtask

  // Small register window for frequent hazards
  task automatic random_mix();
    kind_e       k;
    logic [4:0]  rd, rs1;
    logic [31:0] src;
    begin_test(32'h0000_0800);
    for (int i = 0; i < N_MIX; i++) begin
      k   = kind_e'($unsigned($random(seed)) % 10);
      rd  = $unsigned($random(seed)) % 8;
      rs1 = $unsigned($random(seed)) % 8;
      src = $random(seed);
      if (k <= K_XOR) src = $unsigned($random(seed)) % 8;  // rs2 index
      emit(k, rd, rs1, src);
    end
    run_program("random_mix", 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    reset_i      <= 1'b1;
    fetch_enable <= 1'b0;
    boot_addr    <= 32'h0000_0100;
    prog_len     = 0;
    seed         = 83;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    got_illegal  = 0;
    idle_then_boot();
    immediate_ops();
    dependent_chain();
    lui_and_x0();
    illegal_in_stream();
    random_mix();
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: tb.f
logic/core_pkg.sv
logic/id_ex_if.sv
logic/riscv_fetch.sv
logic/riscv_regfile.sv
logic/riscv_decoder.sv
logic/riscv_alu.sv
logic/riscv_writeback.sv
logic/riscv_core.sv
bench/tb_imem.sv
bench/tb_core.sv

// File: Bender.yml
package:
  name: rv32i_pipeline

sources:
  - logic/core_pkg.sv
  - logic/id_ex_if.sv
  - logic/riscv_fetch.sv
  - logic/riscv_regfile.sv
  - logic/riscv_decoder.sv
  - logic/riscv_alu.sv
  - logic/riscv_writeback.sv
  - logic/riscv_core.sv
  - target: test
    files:
      - bench/tb_imem.sv
      - bench/tb_core.sv
